/* verilog.f */
hdl/max_pool_rd_pkg.sv
hdl/rd_burst_addr_gen.sv
hdl/rd_credit_ctrl.sv
hdl/rd_data_fifo.sv
hdl/rd_stream_out.sv
hdl/max_pool_rd_dma.sv
test/max_pool_rd_dma_assert.sv
test/tb_max_pool_rd_dma.sv

/* Makefile */
SIM      = verilator
TOP      = tb_max_pool_rd_dma
FILELIST = verilog.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module $(TOP)
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 | tee $(LOG)
	grep -q '^sim passed$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* test/tb_max_pool_rd_dma.sv */
`timescale 1ns/1ps

module tb_max_pool_rd_dma;

	localparam int burst_len = 16;
	localparam int addr_outstanding = 2;
	localparam int max_rd_btt = 2048;
	localparam int rd_buffer_depth = 48; // three bursts, not a power of two
	localparam int wait_limit = 5000; // cycles per wait loop

	logic clk;
	logic rst_n;
	logic [31:0] in_ft_map_buf_baseaddr;
	logic [31:0] in_ft_map_buf_len;
	logic mm2s_start;
	logic mm2s_idle;
	logic mm2s_done;
	logic [31:0] m_axi_araddr;
	logic [7:0] m_axi_arlen;
	logic [1:0] m_axi_arburst;
	logic [2:0] m_axi_arsize;
	logic [3:0] m_axi_arcache;
	logic m_axi_arvalid;
	logic m_axi_arready;
	logic [63:0] m_axi_rdata;
	logic [1:0] m_axi_rresp;
	logic m_axi_rlast;
	logic m_axi_rvalid;
	logic m_axi_rready;
	logic [63:0] m_axis_in_ft_map_data;
	logic [7:0] m_axis_in_ft_map_keep;
	logic m_axis_in_ft_map_last;
	logic m_axis_in_ft_map_valid;
	logic m_axis_in_ft_map_ready;

	logic [31:0] rng = 32'h3f16_158c; // handshake stalls
	logic [31:0] len_rng; // random jobs, separate stream
	logic [2:0] stall; // stream ready low when rng slice is below
	logic [39:0] ar_q[$]; // {arlen, araddr} still owed data
	logic [31:0] r_beat = '0; // beat within the head burst
	logic r_taken = 1'b0; // current R beat accepted
	logic [31:0] r_addr;
	logic [31:0] job_base;
	logic [31:0] job_len;
	logic [31:0] exp_addr;
	logic [72:0] exp_beat; // {last, keep, data}
	logic [31:0] beat_n;
	logic [31:0] ar_n;
	logic [31:0] done_n;
	logic done_q = 1'b0;
	logic hung = 1'b0; // a wait timed out, later tests skipped
	int errors = 0;
	int checks = 0;
	int i;

	max_pool_rd_dma #(
		.burst_len(burst_len), .addr_outstanding(addr_outstanding),
		.max_rd_btt(max_rd_btt), .rd_buffer_depth(rd_buffer_depth)
	) dut (.*);

	bind max_pool_rd_dma max_pool_rd_dma_assert #(.addr_outstanding(addr_outstanding)) u_assert (
		.clk(clk), .rst_n(rst_n), .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
		.m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen), .m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready), .m_axi_rlast(m_axi_rlast),
		.m_axis_in_ft_map_valid(m_axis_in_ft_map_valid),
		.m_axis_in_ft_map_ready(m_axis_in_ft_map_ready)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected beat n: data from its byte address, keep up to the final lane
	function automatic logic [72:0] ref_beat(input logic [31:0] base, input logic [31:0] len,
			input logic [31:0] n);
		logic [31:0] addr;
		logic last;
		logic [7:0] keep;
		int b;
		addr = base + (n << 3);
		last = n == (len >> 3);
		for (b = 0; b < 8; b++)
			keep[b] = !last || b <= int'(len[2:0]); // lanes 0 through the final byte
		return {last, keep, ~addr, addr};
	endfunction

	// full bursts, remainder on the final one
	function automatic logic [7:0] ref_arlen(input logic [31:0] len, input logic [31:0] k);
		logic [31:0] beats_m1;
		beats_m1 = len >> 3;
		if (k == beats_m1 / burst_len)
			return 8'(beats_m1 % burst_len);
		return 8'(burst_len - 1);
	endfunction

	task automatic report_mismatch(input string sig, input logic [63:0] got,
			input logic [63:0] want);
		$display("** Error: %s = %h, expected %h at %0t", sig, got, want, $time);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("error: %s at %0t", what, $time);
		errors++;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// AR and R slave plus stream ready, all moved on the falling edge
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			rng = xorshift(rng);
			m_axi_arready = rng[1:0] != 2'd0;
			m_axis_in_ft_map_ready = rng[10:8] >= stall;
			if (!m_axi_rvalid || r_taken) // unaccepted beat stays put
			begin
				r_taken = 1'b0;
				m_axi_rvalid = ar_q.size() > 0 && rng[17:16] != 2'd0;
				if (m_axi_rvalid)
				begin
					r_addr = ar_q[0][31:0] + (r_beat << 3);
					m_axi_rdata = {~r_addr, r_addr}; // address low, inverse high
					m_axi_rlast = r_beat[7:0] == ar_q[0][39:32];
				end
			end
		end
	end

	// handshakes sampled on the rising edge
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (m_axi_arvalid && m_axi_arready)
			begin
				exp_addr = job_base + ar_n * burst_len * 8;
				assert (m_axi_araddr === exp_addr)
					else report_mismatch("m_axi_araddr", 64'(m_axi_araddr), 64'(exp_addr));
				assert (m_axi_arlen === ref_arlen(job_len, ar_n))
					else report_mismatch("m_axi_arlen", 64'(m_axi_arlen),
						64'(ref_arlen(job_len, ar_n)));
				assert (m_axi_arburst === 2'b01) // INCR
					else report_mismatch("m_axi_arburst", 64'(m_axi_arburst), 64'h1);
				assert (m_axi_arsize === 3'b011) // 8 bytes per beat
					else report_mismatch("m_axi_arsize", 64'(m_axi_arsize), 64'h3);
				assert (m_axi_arcache === 4'b0011) // modifiable, bufferable
					else report_mismatch("m_axi_arcache", 64'(m_axi_arcache), 64'h3);
				ar_q.push_back({m_axi_arlen, m_axi_araddr});
				ar_n = ar_n + 1;
			end
			if (m_axi_rvalid && m_axi_rready)
			begin
				r_taken = 1'b1;
				if (m_axi_rlast)
				begin
					void'(ar_q.pop_front()); // burst answered
					r_beat = '0;
				end
				else
					r_beat = r_beat + 1;
			end
			if (m_axis_in_ft_map_valid && m_axis_in_ft_map_ready)
			begin
				exp_beat = ref_beat(job_base, job_len, beat_n);
				checks++;
				assert (beat_n <= (job_len >> 3))
					else report_problem("stream beat after the last one");
				assert (m_axis_in_ft_map_data === exp_beat[63:0])
					else report_mismatch("m_axis_in_ft_map_data", m_axis_in_ft_map_data,
						exp_beat[63:0]);
				assert (m_axis_in_ft_map_keep === exp_beat[71:64])
					else report_mismatch("m_axis_in_ft_map_keep", 64'(m_axis_in_ft_map_keep),
						64'(exp_beat[71:64]));
				assert (m_axis_in_ft_map_last === exp_beat[72])
					else report_mismatch("m_axis_in_ft_map_last", 64'(m_axis_in_ft_map_last),
						64'(exp_beat[72]));
				beat_n = beat_n + 1;
			end
			assert (!mm2s_done || (m_axis_in_ft_map_valid && m_axis_in_ft_map_ready
				&& m_axis_in_ft_map_last))
				else report_problem("mm2s_done without a last stream handshake");
			assert (!done_q || mm2s_idle)
				else report_problem("mm2s_idle not high the clock after mm2s_done");
			if (mm2s_done)
				done_n = done_n + 1;
			done_q = mm2s_done;
		end
	end

	// one job from start to idle, optional start pulse while busy
	task automatic run_test(input int id, input string name, input logic [31:0] base,
			input logic [31:0] len, input logic poke_busy);
		int e0;
		int t;
		e0 = errors;
		if (!hung)
		begin
			job_base = base;
			job_len = len;
			beat_n = '0;
			ar_n = '0;
			done_n = '0;
			in_ft_map_buf_baseaddr = base;
			in_ft_map_buf_len = len;
			mm2s_start = 1'b1;
			@(negedge clk);
			mm2s_start = 1'b0;
			if (poke_busy)
			begin
				@(negedge clk);
				@(negedge clk);
				in_ft_map_buf_baseaddr = base + 32'h0010_0000; // must be ignored
				in_ft_map_buf_len = 32'd7;
				mm2s_start = 1'b1;
				@(negedge clk);
				mm2s_start = 1'b0;
			end
			t = 0;
			while (done_n == 0 && t < wait_limit)
			begin
				@(negedge clk);
				t++;
			end
			if (t >= wait_limit)
			begin
				report_problem("timed out waiting for mm2s_done");
				hung = 1'b1;
			end
			t = 0;
			while (!hung && !mm2s_idle && t < wait_limit)
			begin
				@(negedge clk);
				t++;
			end
			if (t >= wait_limit)
			begin
				report_problem("timed out waiting for mm2s_idle");
				hung = 1'b1;
			end
			assert (hung || beat_n == (len >> 3) + 1)
				else report_problem($sformatf("%0d stream beats, expected %0d", beat_n,
					(len >> 3) + 1));
			assert (hung || ar_n == (len >> 3) / burst_len + 1)
				else report_problem($sformatf("%0d read bursts issued", ar_n));
			assert (hung || done_n == 1)
				else report_problem($sformatf("mm2s_done pulsed %0d times", done_n));
			assert (hung || ar_q.size() == 0)
				else report_problem("read bursts left without data");
		end
		$display("test %0d %s: %s", id, name, (errors == e0 && !hung) ? "ok" : "FAILED");
	endtask

	task automatic finish_run();
		assert (dut.u_assert.fail_cnt == 0)
			else report_problem("bound protocol assertions failed");
		$display("%0d stream beats checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	initial
	begin
		rst_n = 1'b0;
		in_ft_map_buf_baseaddr = '0;
		in_ft_map_buf_len = '0;
		mm2s_start = 1'b0;
		m_axi_arready = 1'b0;
		m_axi_rdata = '0;
		m_axi_rresp = 2'b00; // OKAY
		m_axi_rlast = 1'b0;
		m_axi_rvalid = 1'b0;
		m_axis_in_ft_map_ready = 1'b0;
		stall = 3'd2;
		len_rng = xorshift(32'h3f16_158c ^ 32'h5a5a_5a5a);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		run_test(1, "single partial burst", 32'h0000_1000, 32'd75, 1'b0); // 10 beats, keep 0f
		run_test(2, "multi-burst short tail", 32'h0000_2000, 32'd445, 1'b0); // 3.5 bursts
		stall = 3'd6; // ready one cycle in four
		run_test(3, "stream back-pressure", 32'h0000_4000, 32'd799, 1'b0);
		stall = 3'd2;
		run_test(4, "idle, done and busy start", 32'h0000_8000, 32'd313, 1'b1);
		for (i = 0; i < 4; i++)
		begin
			len_rng = xorshift(len_rng);
			run_test(5, "back-to-back random", {8'd0, len_rng[30:20], 13'd0},
				{22'd0, len_rng[6:0], len_rng[10:8]}, 1'b0);
		end
		finish_run();
	end

endmodule

/* test/max_pool_rd_dma_assert.sv */
`timescale 1ns/1ps

module max_pool_rd_dma_assert #(
	parameter int addr_outstanding = 4
)(
	input logic clk,
	input logic rst_n,
	input logic m_axi_arvalid,
	input logic m_axi_arready,
	input logic [31:0] m_axi_araddr,
	input logic [7:0] m_axi_arlen,
	input logic m_axi_rvalid,
	input logic m_axi_rready,
	input logic m_axi_rlast,
	input logic m_axis_in_ft_map_valid,
	input logic m_axis_in_ft_map_ready
);

	int fail_cnt = 0; // read by the testbench at the end
	logic [5:0] in_flight; // addresses without their last beat back
	logic ar_hs;
	logic r_end;

	assign ar_hs = m_axi_arvalid & m_axi_arready;
	assign r_end = m_axi_rvalid & m_axi_rready & m_axi_rlast;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			in_flight <= '0;
		else
			in_flight <= in_flight + 6'(ar_hs) - 6'(r_end);
	end

	// address held steady while waiting for arready
	ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_arvalid && !m_axi_arready |=>
		m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
	else
	begin
		$error("arvalid dropped or AR fields changed before arready");
		fail_cnt = fail_cnt + 1;
	end

	ar_limit: assert property (@(posedge clk) disable iff (!rst_n)
		in_flight <= 6'(addr_outstanding))
	else
	begin
		$error("more read addresses in flight than allowed");
		fail_cnt = fail_cnt + 1;
	end

	// stream valid sticks until taken
	tvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_axis_in_ft_map_valid && !m_axis_in_ft_map_ready |=> m_axis_in_ft_map_valid)
	else
	begin
		$error("stream valid dropped without ready");
		fail_cnt = fail_cnt + 1;
	end

endmodule

/* hdl/max_pool_rd_dma.sv */
`timescale 1ns/1ps

module max_pool_rd_dma #(
	parameter int burst_len = 32, // 2 to 256, power of two
	parameter int addr_outstanding = 4, // 1 to 16
	parameter int max_rd_btt = 2048, // largest job in bytes
	parameter int rd_buffer_depth = 512 // multiple of burst_len
)(
	input  logic clk,
	input  logic rst_n,
	input  logic [max_pool_rd_pkg::addr_w-1:0] in_ft_map_buf_baseaddr,
	input  logic [31:0] in_ft_map_buf_len, // bytes - 1
	input  logic mm2s_start,
	output logic mm2s_idle,
	output logic mm2s_done,
	output logic [max_pool_rd_pkg::addr_w-1:0] m_axi_araddr,
	output logic [7:0] m_axi_arlen,
	output logic [1:0] m_axi_arburst,
	output logic [2:0] m_axi_arsize,
	output logic [3:0] m_axi_arcache,
	output logic m_axi_arvalid,
	input  logic m_axi_arready,
	input  logic [max_pool_rd_pkg::data_w-1:0] m_axi_rdata,
	input  logic [1:0] m_axi_rresp, // not checked
	input  logic m_axi_rlast,
	input  logic m_axi_rvalid,
	output logic m_axi_rready,
	output logic [max_pool_rd_pkg::data_w-1:0] m_axis_in_ft_map_data,
	output logic [max_pool_rd_pkg::keep_w-1:0] m_axis_in_ft_map_keep,
	output logic m_axis_in_ft_map_last,
	output logic m_axis_in_ft_map_valid,
	input  logic m_axis_in_ft_map_ready
);

	logic job_start;
	logic issue_ok;
	logic ar_fire;
	logic burst_end;

	// fixed AR fields, INCR of 8-byte beats
	assign m_axi_arburst = max_pool_rd_pkg::axi_burst_incr;
	assign m_axi_arsize = max_pool_rd_pkg::axi_size_8b;
	assign m_axi_arcache = max_pool_rd_pkg::axi_cache_mod;

	rd_burst_addr_gen #(.burst_len(burst_len), .max_rd_btt(max_rd_btt)) u_addr_gen (
		.clk(clk), .rst_n(rst_n),
		.base_addr(in_ft_map_buf_baseaddr), .buf_len(in_ft_map_buf_len),
		.job_start(job_start), .mm2s_idle(mm2s_idle), .mm2s_done(mm2s_done),
		.issue_ok(issue_ok), .arready(m_axi_arready),
		.araddr(m_axi_araddr), .arlen(m_axi_arlen), .arvalid(m_axi_arvalid),
		.ar_fire(ar_fire)
	);

	rd_credit_ctrl #(
		.burst_len(burst_len), .addr_outstanding(addr_outstanding),
		.rd_buffer_depth(rd_buffer_depth)
	) u_credit (
		.clk(clk), .rst_n(rst_n), .ar_fire(ar_fire),
		.rvalid(m_axi_rvalid), .rready(m_axi_rready), .rlast(m_axi_rlast),
		.burst_end(burst_end), .issue_ok(issue_ok)
	);

	// stream ready pops the FIFO directly
	rd_data_fifo #(.depth(rd_buffer_depth)) u_fifo (
		.clk(clk), .rst_n(rst_n),
		.rdata(m_axi_rdata), .rlast(m_axi_rlast), .rvalid(m_axi_rvalid),
		.pop(m_axis_in_ft_map_ready), .rready(m_axi_rready),
		.dout(m_axis_in_ft_map_data), .dout_valid(m_axis_in_ft_map_valid),
		.burst_end(burst_end)
	);

	rd_stream_out #(.max_rd_btt(max_rd_btt)) u_stream (
		.clk(clk), .rst_n(rst_n), .buf_len(in_ft_map_buf_len),
		.mm2s_start(mm2s_start), .dout_valid(m_axis_in_ft_map_valid),
		.tready(m_axis_in_ft_map_ready), .job_start(job_start),
		.mm2s_idle(mm2s_idle), .mm2s_done(mm2s_done),
		.tkeep(m_axis_in_ft_map_keep), .tlast(m_axis_in_ft_map_last)
	);

endmodule

/* hdl/rd_stream_out.sv */
`timescale 1ns/1ps

module rd_stream_out #(
	parameter int max_rd_btt = 2048
)(
	input  logic clk,
	input  logic rst_n,
	input  max_pool_rd_pkg::buf_len_u buf_len,
	input  logic mm2s_start,
	input  logic dout_valid, // FIFO not empty, same as stream valid
	input  logic tready,
	output logic job_start,
	output logic mm2s_idle,
	output logic mm2s_done,
	output logic [max_pool_rd_pkg::keep_w-1:0] tkeep,
	output logic tlast
);

	localparam int cnt_w = $clog2(max_rd_btt / max_pool_rd_pkg::beat_bytes);
	localparam int keep_w = max_pool_rd_pkg::keep_w;

	logic idle_q;
	logic [cnt_w-1:0] idx_q; // final beat index of the job
	logic [keep_w-1:0] keep_q; // keep mask for the final beat
	logic [cnt_w-1:0] beat_cnt; // stream beats sent so far
	logic hs; // stream handshake

	assign mm2s_idle = idle_q;
	assign job_start = idle_q & mm2s_start; // start while busy is dropped
	assign hs = dout_valid & tready;

	assign tlast = beat_cnt == idx_q;
	assign tkeep = tlast ? keep_q : '1;
	assign mm2s_done = hs & tlast;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			idle_q <= 1'b1;
		else if (idle_q)
			idle_q <= ~mm2s_start;
		else
			idle_q <= mm2s_done; // back to idle after the last beat
	end

	// job length, taken once per start
	always_ff @(posedge clk)
	begin
		if (job_start)
		begin
			idx_q <= buf_len.f.beat_idx[cnt_w-1:0];
			// lanes 0 up to the final byte lane
			keep_q <= {keep_w{1'b1}} >> (3'd7 - buf_len.f.lane);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			beat_cnt <= '0;
		else if (job_start)
			beat_cnt <= '0;
		else if (hs)
			beat_cnt <= beat_cnt + 1'b1;
	end

endmodule

/* hdl/rd_data_fifo.sv */
`timescale 1ns/1ps

module rd_data_fifo #(
	parameter int depth = 512 // beats, at least one burst
)(
	input  logic clk,
	input  logic rst_n,
	input  logic [max_pool_rd_pkg::data_w-1:0] rdata,
	input  logic rlast,
	input  logic rvalid,
	input  logic pop, // stream ready
	output logic rready,
	output logic [max_pool_rd_pkg::data_w-1:0] dout,
	output logic dout_valid,
	output logic burst_end
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	logic [max_pool_rd_pkg::data_w-1:0] mem_data [depth]; // beat payload
	logic mem_last [depth]; // rlast kept beside each beat
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic push;
	logic pop_fire;

	assign rready = count != cnt_w'(depth); // not full
	assign dout_valid = count != '0; // not empty
	assign push = rvalid & rready;
	assign pop_fire = pop & dout_valid;

	// fall-through read, head entry always on the output
	assign dout = mem_data[rd_ptr];
	assign burst_end = pop_fire & mem_last[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem_data[wr_ptr] <= rdata;
			mem_last[wr_ptr] <= rlast;
		end
	end

	// pointers wrap at depth, which need not be a power of two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_fire)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (push & ~pop_fire)
				count <= count + 1'b1;
			else if (pop_fire & ~push)
				count <= count - 1'b1;
		end
	end

endmodule

/* hdl/rd_credit_ctrl.sv */
`timescale 1ns/1ps

module rd_credit_ctrl #(
	parameter int burst_len = 32,
	parameter int addr_outstanding = 4, // read addresses in flight, 1 to 16
	parameter int rd_buffer_depth = 512 // FIFO depth in beats
)(
	input  logic clk,
	input  logic rst_n,
	input  logic ar_fire, // address accepted
	input  logic rvalid,
	input  logic rready,
	input  logic rlast,
	input  logic burst_end, // final beat of a burst left the FIFO
	output logic issue_ok
);

	// bursts that fit in the read buffer
	localparam int store_n = rd_buffer_depth / burst_len;
	localparam int out_w = $clog2(addr_outstanding + 1);
	localparam int buf_w = $clog2(store_n + 1);

	logic [out_w-1:0] out_cnt; // addresses without all data returned
	logic out_ok; // registered not-full for out_cnt
	logic [buf_w-1:0] buf_cnt; // bursts holding a buffer reservation
	logic buf_ok;
	logic r_done; // last beat of a burst accepted on R

	assign r_done = rvalid & rready & rlast;
	assign issue_ok = out_ok & buf_ok;

	// outstanding address count
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_cnt <= '0;
			out_ok <= 1'b1;
		end
		else if (ar_fire ^ r_done) // both at once leaves count unchanged
		begin
			out_cnt <= ar_fire ? out_cnt + 1'b1 : out_cnt - 1'b1;
			// full only when this increment reaches the limit
			out_ok <= ~ar_fire | (out_cnt != out_w'(addr_outstanding - 1));
		end
	end

	// buffer reservation count, released as the burst drains out
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			buf_cnt <= '0;
			buf_ok <= 1'b1;
		end
		else if (ar_fire ^ burst_end)
		begin
			buf_cnt <= ar_fire ? buf_cnt + 1'b1 : buf_cnt - 1'b1;
			buf_ok <= ~ar_fire | (buf_cnt != buf_w'(store_n - 1));
		end
	end

endmodule

/* hdl/rd_burst_addr_gen.sv */
`timescale 1ns/1ps

module rd_burst_addr_gen #(
	parameter int burst_len = 32, // beats in a full burst
	parameter int max_rd_btt = 2048 // largest job in bytes
)(
	input  logic clk,
	input  logic rst_n,
	input  logic [max_pool_rd_pkg::addr_w-1:0] base_addr,
	input  max_pool_rd_pkg::buf_len_u buf_len,
	input  logic job_start, // start accepted while idle
	input  logic mm2s_idle,
	input  logic mm2s_done,
	input  logic issue_ok, // credits available
	input  logic arready,
	output logic [max_pool_rd_pkg::addr_w-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	output logic ar_fire
);

	// beat index width, covers max_rd_btt/8 - 1
	localparam int cnt_w = $clog2(max_rd_btt / max_pool_rd_pkg::beat_bytes);
	// address step per accepted burst
	localparam int burst_bytes = burst_len << max_pool_rd_pkg::beat_shift;

	logic [max_pool_rd_pkg::addr_w-1:0] ar_addr;
	logic [cnt_w-1:0] remaining; // beats still to request, minus one
	logic suppress; // final burst already accepted
	logic last_burst;

	assign last_burst = remaining <= cnt_w'(burst_len - 1);

	// short length only on the final burst
	assign arlen = last_burst ? 8'(remaining) : 8'(burst_len - 1);
	assign araddr = ar_addr;

	// busy, not yet finished, and room in both credit pools
	assign arvalid = ~mm2s_idle & ~suppress & issue_ok;
	assign ar_fire = arvalid & arready;

	// burst address, stepped on every accepted address
	always_ff @(posedge clk)
	begin
		if (job_start)
			ar_addr <= base_addr;
		else if (ar_fire)
			ar_addr <= ar_addr + max_pool_rd_pkg::addr_w'(burst_bytes);
	end

	// remaining beat count
	always_ff @(posedge clk)
	begin
		if (job_start)
			remaining <= buf_len.f.beat_idx[cnt_w-1:0]; // beats - 1 from field view
		else if (ar_fire)
			remaining <= remaining - cnt_w'(burst_len);
	end

	// hold arvalid low once the final address went out, until done
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			suppress <= 1'b0;
		else if (suppress)
			suppress <= ~mm2s_done;
		else
			suppress <= ar_fire & last_burst;
	end

endmodule

/* hdl/max_pool_rd_pkg.sv */
package max_pool_rd_pkg;

	// bus widths
	localparam int addr_w = 32;
	localparam int data_w = 64;
	localparam int beat_bytes = 8; // bytes per 64-bit beat
	localparam int beat_shift = 3; // log2 of beat_bytes
	localparam int keep_w = 8;

	// fixed AR channel codes
	localparam logic [1:0] axi_burst_incr = 2'b01;
	localparam logic [2:0] axi_size_8b = 3'b011; // 8 bytes per transfer
	localparam logic [3:0] axi_cache_mod = 4'b0011; // modifiable, bufferable

	// beat index plus lane of the final byte
	typedef struct packed {
		logic [31-beat_shift:0] beat_idx; // beats - 1
		logic [beat_shift-1:0] lane; // byte lane of the final byte
	} buf_len_f_t;

	// length word, byte count minus one
	// same bits seen as raw count or as beat/lane split
	typedef union packed {
		logic [31:0] raw;
		buf_len_f_t f;
	} buf_len_u;

endpackage
